/* source/conv_config.svh */
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

`define CONV_BIT_LEN   8     // pixel width
`define CONV_M_LEN     3     // kernel side
`define CONV_FEA_SIZE  417   // feature map entries
`define CONV_ADDR_W    9     // wide enough to hold CONV_FEA_SIZE itself

// kernel weights, unsigned
// CONV_K<row><col>: row is the pixel inside a column (0 = lower),
// col is the window column (0 = oldest)
`define CONV_K00  `CONV_BIT_LEN'(1)
`define CONV_K01  `CONV_BIT_LEN'(1)
`define CONV_K02  `CONV_BIT_LEN'(1)
`define CONV_K10  `CONV_BIT_LEN'(1)
`define CONV_K11  `CONV_BIT_LEN'(1)
`define CONV_K12  `CONV_BIT_LEN'(1)
`define CONV_K20  `CONV_BIT_LEN'(1)
`define CONV_K21  `CONV_BIT_LEN'(1)
`define CONV_K22  `CONV_BIT_LEN'(1)

`endif

/* source/conv_types_pkg.sv */
`include "conv_config.svh"

package conv_types_pkg;

    // one camera pixel
    typedef logic [`CONV_BIT_LEN-1:0] pixel_t;

    // one column of the window, p0 sits in the low bits
    typedef struct packed {
        pixel_t p2;    // upper
        pixel_t p1;
        pixel_t p0;    // lower
    } column_t;

    // three columns, c0 is the oldest and sits in the low bits
    typedef struct packed {
        column_t c2;   // newest
        column_t c1;
        column_t c0;   // oldest
    } window_t;

    // feature map address, also used for the write pointer
    typedef logic [`CONV_ADDR_W-1:0] fm_addr_t;

endpackage

/* source/conv_ctrl_pkg.sv */
package conv_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        WORK  = 2'b01,
        PAUSE = 2'b10
    } conv_state_e;

    // number of valid columns in the window, saturates at 3
    typedef logic [1:0] fill_t;

    // strobes from the controller to the window and the MAC
    typedef struct packed {
        logic shift;     // take i_column this cycle
        logic clear;     // zero the window
        logic full_new;  // window became a new full window at the last edge
    } win_ctrl_t;

endpackage

/* source/conv_ctrl.sv */
`timescale 1ns/1ps

module conv_ctrl (
    input  logic                    i_Clk,
    input  logic                    i_reset,
    input  logic                    i_f_start,
    input  logic                    i_f_stop,
    output conv_ctrl_pkg::win_ctrl_t o_win_ctrl
);

    conv_ctrl_pkg::conv_state_e state_q;
    conv_ctrl_pkg::conv_state_e state_d;
    conv_ctrl_pkg::fill_t       fill_q;
    conv_ctrl_pkg::fill_t       fill_d;
    logic                       full_new_q;

    always_comb begin
        state_d = state_q;
        fill_d  = fill_q;
        case (state_q)
            conv_ctrl_pkg::IDLE: begin
                fill_d = '0;
                if (i_f_start)
                    state_d = conv_ctrl_pkg::WORK;
            end
            conv_ctrl_pkg::WORK: begin
                // the column is taken even on the stop edge
                if (fill_q != conv_ctrl_pkg::fill_t'(3))
                    fill_d = fill_q + conv_ctrl_pkg::fill_t'(1);
                if (i_f_stop)
                    state_d = conv_ctrl_pkg::PAUSE;
            end
            conv_ctrl_pkg::PAUSE: begin
                if (i_f_start)
                    state_d = conv_ctrl_pkg::WORK;   // start wins over stop
                else if (i_f_stop)
                    state_d = conv_ctrl_pkg::IDLE;
            end
            default: begin
                state_d = conv_ctrl_pkg::IDLE;
                fill_d  = '0;
            end
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_reset) begin
        if (!i_reset) begin
            state_q    <= conv_ctrl_pkg::IDLE;
            fill_q     <= '0;
            full_new_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            fill_q     <= fill_d;
            // two columns held plus the one shifted now make a full window
            full_new_q <= (state_q == conv_ctrl_pkg::WORK) &&
                          (fill_q >= conv_ctrl_pkg::fill_t'(2));
        end
    end

    assign o_win_ctrl.shift    = (state_q == conv_ctrl_pkg::WORK);
    assign o_win_ctrl.clear    = (state_q == conv_ctrl_pkg::IDLE);
    assign o_win_ctrl.full_new = full_new_q;

    // only the three defined encodings may ever be stored
    a_state_legal: assert property (
        @(posedge i_Clk) disable iff (!i_reset)
        state_q inside {conv_ctrl_pkg::IDLE, conv_ctrl_pkg::WORK, conv_ctrl_pkg::PAUSE}
    ) else $error("conv_ctrl: illegal state encoding %b", state_q);

endmodule

/* source/conv_window.sv */
`timescale 1ns/1ps

module conv_window (
    input  logic                     i_Clk,
    input  logic                     i_reset,
    input  conv_ctrl_pkg::win_ctrl_t i_win_ctrl,
    input  conv_types_pkg::column_t  i_column,
    output conv_types_pkg::window_t  o_window
);

    conv_types_pkg::window_t win_q;

    always_ff @(posedge i_Clk or negedge i_reset) begin
        if (!i_reset) begin
            win_q <= '0;
        end else if (i_win_ctrl.clear) begin
            win_q <= '0;
        end else if (i_win_ctrl.shift) begin
            win_q.c0 <= win_q.c1;   // oldest drops out
            win_q.c1 <= win_q.c2;
            win_q.c2 <= i_column;
        end
    end

    assign o_window = win_q;

    // controller derives both from one state, so they must never overlap
    a_shift_clear_excl: assert property (
        @(posedge i_Clk) disable iff (!i_reset)
        !(i_win_ctrl.shift && i_win_ctrl.clear)
    ) else $error("conv_window: shift and clear high together");

endmodule

/* source/conv_mac.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module conv_mac (
    input  logic                    i_Clk,
    input  logic                    i_reset,
    input  conv_types_pkg::window_t i_window,
    input  logic                    i_full_new,
    output conv_types_pkg::pixel_t  o_data,
    output logic                    o_valid
);

    localparam int BW    = `CONV_BIT_LEN;
    localparam int TAPS  = `CONV_M_LEN * `CONV_M_LEN;
    localparam int SUM_W = 2 * BW + $clog2(TAPS);  // nine full products never overflow

    // tap i = column * 3 + row, same order as the packed window
    localparam logic [TAPS-1:0][BW-1:0] KERNEL = {
        `CONV_K22, `CONV_K12, `CONV_K02,
        `CONV_K21, `CONV_K11, `CONV_K01,
        `CONV_K20, `CONV_K10, `CONV_K00
    };

    logic [TAPS-1:0][BW-1:0] win_px;
    logic [SUM_W-1:0]        sum;

    assign win_px = i_window;

    always_comb begin
        sum = '0;
        for (int i = 0; i < TAPS; i++) begin
            sum = sum + SUM_W'(win_px[i]) * SUM_W'(KERNEL[i]);
        end
    end

    always_ff @(posedge i_Clk or negedge i_reset) begin
        if (!i_reset) begin
            o_data  <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_full_new;
            if (i_full_new)
                o_data <= sum[BW-1:0];   // wraps to pixel width
        end
    end

    // back to back results need back to back full windows
    a_valid_run: assert property (
        @(posedge i_Clk) disable iff (!i_reset)
        (o_valid && $past(o_valid)) |-> ($past(i_full_new) && $past(i_full_new, 2))
    ) else $error("conv_mac: o_valid run without full windows");

endmodule

/* source/feature_map_ram.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module feature_map_ram (
    input  logic                     i_Clk,
    input  logic                     i_reset,
    input  logic                     i_clear,
    input  logic                     i_wr_en,
    input  conv_types_pkg::pixel_t   i_wr_data,
    input  conv_types_pkg::fm_addr_t i_rd_addr,
    output conv_types_pkg::pixel_t   o_rd_data,
    output logic                     o_fm_full
);

    conv_types_pkg::pixel_t   mem [0:`CONV_FEA_SIZE-1];
    conv_types_pkg::fm_addr_t wr_ptr;
    logic                     wr_ok;

    assign o_fm_full = (wr_ptr == conv_types_pkg::fm_addr_t'(`CONV_FEA_SIZE));
    assign wr_ok     = i_wr_en && !o_fm_full && !i_clear;  // late writes after full are lost

    always_ff @(posedge i_Clk or negedge i_reset) begin
        if (!i_reset)
            wr_ptr <= '0;
        else if (i_clear)
            wr_ptr <= '0;
        else if (wr_ok)
            wr_ptr <= wr_ptr + conv_types_pkg::fm_addr_t'(1);
    end

    always_ff @(posedge i_Clk) begin
        if (wr_ok)
            mem[wr_ptr] <= i_wr_data;
        // out of range reads return zero
        if (i_rd_addr < conv_types_pkg::fm_addr_t'(`CONV_FEA_SIZE))
            o_rd_data <= mem[i_rd_addr];
        else
            o_rd_data <= '0;
    end

    a_ptr_range: assert property (
        @(posedge i_Clk) disable iff (!i_reset)
        wr_ptr <= conv_types_pkg::fm_addr_t'(`CONV_FEA_SIZE)
    ) else $error("feature_map_ram: write pointer past end (%0d)", wr_ptr);

endmodule

/* source/conv_top.sv */
`timescale 1ns/1ps

module conv_top (
    input  logic                     i_Clk,
    input  logic                     i_reset,
    input  conv_types_pkg::column_t  i_column,
    input  logic                     i_f_start,
    input  logic                     i_f_stop,
    input  conv_types_pkg::fm_addr_t i_rd_addr,
    output conv_types_pkg::pixel_t   o_data,
    output logic                     o_valid,
    output logic                     o_fm_full,
    output conv_types_pkg::pixel_t   o_rd_data
);

    conv_ctrl_pkg::win_ctrl_t win_ctrl;
    conv_types_pkg::window_t  window;

    conv_ctrl u_ctrl (
        .i_Clk      (i_Clk),
        .i_reset    (i_reset),
        .i_f_start  (i_f_start),
        .i_f_stop   (i_f_stop),
        .o_win_ctrl (win_ctrl)
    );

    conv_window u_window (
        .i_Clk      (i_Clk),
        .i_reset    (i_reset),
        .i_win_ctrl (win_ctrl),
        .i_column   (i_column),
        .o_window   (window)
    );

    conv_mac u_mac (
        .i_Clk      (i_Clk),
        .i_reset    (i_reset),
        .i_window   (window),
        .i_full_new (win_ctrl.full_new),
        .o_data     (o_data),
        .o_valid    (o_valid)
    );

    // every streamed result is also stored; IDLE rewinds the pointer
    feature_map_ram u_fm_ram (
        .i_Clk      (i_Clk),
        .i_reset    (i_reset),
        .i_clear    (win_ctrl.clear),
        .i_wr_en    (o_valid),
        .i_wr_data  (o_data),
        .i_rd_addr  (i_rd_addr),
        .o_rd_data  (o_rd_data),
        .o_fm_full  (o_fm_full)
    );

endmodule

/* sim/tb_conv_top.sv */
`timescale 1ns/1ps
`include "conv_config.svh"

module tb_conv_top;

    localparam int FEA        = `CONV_FEA_SIZE;
    localparam int RESET_CYC  = 16;
    localparam int WARM_CYC   = 200;            // first random stream
    localparam int IDLE_CYC   = 12;             // pause, return to IDLE, restart
    localparam int RUN_CYC    = 2 * (FEA + 8);  // long stream, pauses included
    localparam int READ_CYC   = FEA + 8;        // drain plus readback
    localparam int MAX_CYCLES = 2 * (RESET_CYC + WARM_CYC + IDLE_CYC + RUN_CYC + READ_CYC);

    logic                     i_Clk;
    logic                     i_reset;
    conv_types_pkg::column_t  i_column;
    logic                     i_f_start;
    logic                     i_f_stop;
    conv_types_pkg::fm_addr_t i_rd_addr;
    conv_types_pkg::pixel_t   o_data;
    logic                     o_valid;
    logic                     o_fm_full;
    conv_types_pkg::pixel_t   o_rd_data;

    integer seed = 32'hf2c9_3856;
    int     cycle_cnt = 0;
    int     mismatch_cnt = 0;
    int     other_err_cnt = 0;

    // reference model
    conv_ctrl_pkg::conv_state_e m_state;
    int m_fill;
    int m_px [0:2][0:2];    // [column][row], column 0 is the oldest
    int kernel [0:2][0:2];  // [row][column]
    int exp_data [$];
    int exp_due [$];        // edge count at which o_valid must show the result
    int m_valid;
    int m_data;
    int fm_model [0:FEA-1];
    int fm_ptr;
    int run_results;        // results since the last IDLE

    conv_top DUT (
        .i_Clk     (i_Clk),
        .i_reset   (i_reset),
        .i_column  (i_column),
        .i_f_start (i_f_start),
        .i_f_stop  (i_f_stop),
        .i_rd_addr (i_rd_addr),
        .o_data    (o_data),
        .o_valid   (o_valid),
        .o_fm_full (o_fm_full),
        .o_rd_data (o_rd_data)
    );

    initial i_Clk = 1'b0;
    always #10 i_Clk = ~i_Clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    function automatic int window_sum();
        int s;
        s = 0;
        for (int c = 0; c < 3; c++)
            for (int r = 0; r < 3; r++)
                s += m_px[c][r] * kernel[r][c];
        return s % (1 << `CONV_BIT_LEN);  // result wraps to pixel width
    endfunction

    task automatic reset_model();
        m_state = conv_ctrl_pkg::IDLE;
        m_fill = 0;
        for (int c = 0; c < 3; c++)
            for (int r = 0; r < 3; r++)
                m_px[c][r] = 0;
        exp_data.delete();
        exp_due.delete();
        m_valid = 0;
        m_data = 0;
        fm_ptr = 0;
        run_results = 0;
    endtask

    // state, window and fill at one edge
    task automatic update_model(input logic start, input logic stop,
                                input conv_types_pkg::column_t col);
        case (m_state)
            conv_ctrl_pkg::IDLE: begin
                m_fill = 0;
                run_results = 0;
                for (int c = 0; c < 3; c++)
                    for (int r = 0; r < 3; r++)
                        m_px[c][r] = 0;
                if (start)
                    m_state = conv_ctrl_pkg::WORK;
            end
            conv_ctrl_pkg::WORK: begin
                for (int c = 0; c < 2; c++)
                    for (int r = 0; r < 3; r++)
                        m_px[c][r] = m_px[c + 1][r];
                m_px[2][0] = col.p0;
                m_px[2][1] = col.p1;
                m_px[2][2] = col.p2;
                if (m_fill >= 2) begin
                    exp_data.push_back(window_sum());
                    exp_due.push_back(cycle_cnt + 1);
                end
                if (m_fill < 3)
                    m_fill++;
                if (stop)
                    m_state = conv_ctrl_pkg::PAUSE;
            end
            default: begin
                if (start)
                    m_state = conv_ctrl_pkg::WORK;
                else if (stop)
                    m_state = conv_ctrl_pkg::IDLE;
            end
        endcase
    endtask

    // one clock edge: check outputs, then advance the model; returns 2 ns after the edge
    task automatic tick();
        logic                    rst_now;
        logic                    start_now;
        logic                    stop_now;
        conv_types_pkg::column_t col_now;
        @(posedge i_Clk);
        rst_now = i_reset;
        start_now = i_f_start;
        stop_now = i_f_stop;
        col_now = i_column;
        cycle_cnt++;
        #1;
        if (!rst_now) begin
            reset_model();
        end else begin
            if (m_state == conv_ctrl_pkg::IDLE) begin
                fm_ptr = 0;
            end else if (m_valid != 0 && fm_ptr < FEA) begin
                fm_model[fm_ptr] = m_data;
                fm_ptr++;
            end
            m_valid = 0;
            if (exp_due.size() > 0 && exp_due[0] == cycle_cnt) begin
                m_valid = 1;
                m_data = exp_data.pop_front();
                void'(exp_due.pop_front());
                run_results++;
            end
        end
        if (o_valid === 1'b1 && m_valid == 0 && exp_due.size() == 0) begin
            other_err_cnt++;
            $display("error at %0t: o_valid pulsed while no result was expected", $time);
        end else begin
            check_value(o_valid, m_valid, "o_valid");
        end
        check_value(o_data, m_data, "o_data");
        check_value(o_fm_full, fm_ptr == FEA, "o_fm_full");
        if (rst_now)
            update_model(start_now, stop_now, col_now);
        #1;
    endtask

    task automatic drive_cycle(input logic start, input logic stop);
        logic [31:0] rnd;
        rnd = $random(seed);
        i_column = rnd[23:0];
        i_f_start = start;
        i_f_stop = stop;
        tick();
    endtask

    // random stop in WORK, random resume in PAUSE
    task automatic stream_cycle();
        logic start;
        logic stop;
        start = 1'b0;
        stop = 1'b0;
        case (m_state)
            conv_ctrl_pkg::WORK:  stop = (($random(seed) & 15) == 0);
            conv_ctrl_pkg::PAUSE: start = (($random(seed) & 3) == 0);
            default:              start = 1'b1;
        endcase
        drive_cycle(start, stop);
    endtask

    always @(negedge i_Clk) begin
        if (cycle_cnt > MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_err_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        kernel[0][0] = `CONV_K00;
        kernel[0][1] = `CONV_K01;
        kernel[0][2] = `CONV_K02;
        kernel[1][0] = `CONV_K10;
        kernel[1][1] = `CONV_K11;
        kernel[1][2] = `CONV_K12;
        kernel[2][0] = `CONV_K20;
        kernel[2][1] = `CONV_K21;
        kernel[2][2] = `CONV_K22;
        reset_model();
        i_reset = 1'b0;
        i_column = '0;
        i_f_start = 1'b0;
        i_f_stop = 1'b0;
        i_rd_addr = '0;

        repeat (RESET_CYC) tick();
        i_reset = 1'b1;
        check_value(o_valid, 0, "o_valid after reset");
        check_value(o_data, 0, "o_data after reset");
        check_value(o_fm_full, 0, "o_fm_full after reset");

        drive_cycle(1'b1, 1'b0);
        repeat (WARM_CYC) stream_cycle();

        // pause, then a second stop drops back to IDLE
        while (m_state != conv_ctrl_pkg::WORK)
            drive_cycle(1'b1, 1'b0);
        drive_cycle(1'b0, 1'b1);
        repeat (2) drive_cycle(1'b0, 1'b0);
        drive_cycle(1'b0, 1'b1);
        repeat (3) drive_cycle(1'b0, 1'b0);
        drive_cycle(1'b1, 1'b0);
        repeat (3) begin
            drive_cycle(1'b0, 1'b0);
            check_value(o_valid, 0, "o_valid before window refilled");
        end

        // stream until the map has overflowed
        while (run_results <= FEA + 4)
            stream_cycle();
        while (m_state != conv_ctrl_pkg::PAUSE)
            drive_cycle(1'b0, m_state == conv_ctrl_pkg::WORK);
        repeat (3) drive_cycle(1'b0, 1'b0);  // let the pipeline drain
        check_value(o_fm_full, 1, "o_fm_full after full map");

        for (int a = 0; a <= FEA; a++) begin
            i_rd_addr = a;
            drive_cycle(1'b0, 1'b0);
            if (a < FEA)
                check_value(o_rd_data, fm_model[a], $sformatf("o_rd_data at address %0d", a));
            else
                check_value(o_rd_data, 0, "o_rd_data past the end");
        end

        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_err_cnt);
        if (mismatch_cnt + other_err_cnt == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+source
source/conv_types_pkg.sv
source/conv_ctrl_pkg.sv
source/conv_ctrl.sv
source/conv_window.sv
source/conv_mac.sv
source/feature_map_ram.sv
source/conv_top.sv
sim/tb_conv_top.sv

/* Bender.yml */
package:
  name: conv_engine

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/conv_types_pkg.sv
      - source/conv_ctrl_pkg.sv
      - source/conv_ctrl.sv
      - source/conv_window.sv
      - source/conv_mac.sv
      - source/feature_map_ram.sv
      - source/conv_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_conv_top.sv
